//--- test/soc_vectors.mem
// kind op address wdata expected
// kind: 0 store, 1 load, 2 store unmapped, 3 load unmapped, f end of records
0 2 00000010 12345678 00000000
1 2 00000010 00000000 12345678
0 2 00000014 cafef00d 00000000
1 2 00000014 00000000 cafef00d
0 0 00000011 000000a5 00000000
1 2 00000010 00000000 1234a578
1 0 00000011 00000000 ffffffa5
1 4 00000011 00000000 000000a5
1 0 00000013 00000000 00000012
0 1 00000012 ffff8001 00000000
1 2 00000010 00000000 8001a578
1 1 00000012 00000000 ffff8001
1 5 00000012 00000000 00008001
1 1 00000010 00000000 ffffa578
1 5 00000010 00000000 0000a578
0 0 00000014 1234567f 00000000
1 2 00000014 00000000 cafef07f
1 0 00000014 00000000 0000007f
0 2 00000400 0badc0de 00000000
1 2 00000000 00000000 0badc0de
2 2 40000000 ffffffff 00000000
3 2 40000004 00000000 00000000
1 2 00000014 00000000 cafef07f
f 0 00000000 00000000 00000000

//--- tb.f
hw/soc_pkg.sv
hw/wb_master_bridge.sv
hw/wb_addr_decoder.sv
hw/wb_data_ram.sv
hw/gpio_regs.sv
hw/clint_timer.sv
hw/soc_bus_top.sv
test/soc_assertions.sv
test/tb_soc.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_soc -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_soc)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

//--- test/tb_soc.sv
`timescale 1ns/1ps

module tb_soc;

    // ==============================
    // limits and address map
    // ==============================
    localparam int STALL_LIMIT   = 20;
    localparam int IRQ_LIMIT     = 200;
    localparam int VEC_RECORDS   = 48;
    localparam int RAND_ACCESSES = 16;

    localparam logic [31:0] GPIO_OUT_ADR = {soc_pkg::REGION_GPIO, 24'h0, soc_pkg::GPIO_OUT_OFS};
    localparam logic [31:0] GPIO_OE_ADR  = {soc_pkg::REGION_GPIO, 24'h0, soc_pkg::GPIO_OE_OFS};
    localparam logic [31:0] GPIO_IN_ADR  = {soc_pkg::REGION_GPIO, 24'h0, soc_pkg::GPIO_IN_OFS};
    localparam logic [31:0] MTIME_LO_ADR =
        {soc_pkg::REGION_CLINT, 24'h0, soc_pkg::CLINT_MTIME_LO_OFS};
    localparam logic [31:0] MTIME_HI_ADR =
        {soc_pkg::REGION_CLINT, 24'h0, soc_pkg::CLINT_MTIME_HI_OFS};
    localparam logic [31:0] CMP_LO_ADR = {soc_pkg::REGION_CLINT, 24'h0, soc_pkg::CLINT_CMP_LO_OFS};
    localparam logic [31:0] CMP_HI_ADR = {soc_pkg::REGION_CLINT, 24'h0, soc_pkg::CLINT_CMP_HI_OFS};

    logic               clk;
    logic               rst_n;
    soc_pkg::proc_req_t proc_req;
    logic [31:0]        proc_rdata;
    logic               proc_stall;
    logic               bus_err;
    logic [31:0]        gpio_in;
    logic [31:0]        gpio_out;
    logic [31:0]        gpio_oe;
    logic               timer_irq;

    // five words per record: kind, op, address, write data, expected
    logic [31:0] vec_words [VEC_RECORDS*5];
    // dmem reference, word index wraps at the depth
    logic [31:0] model_mem [soc_pkg::DMEM_WORDS];
    logic [31:0] rnd_addr [RAND_ACCESSES];
    logic [31:0] rnd_data [RAND_ACCESSES];
    int          check_count;
    int          error_count;
    int          timeout_count;

    soc_bus_top soc_bus_top_i (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .proc_req_i   (proc_req),
        .proc_rdata_o (proc_rdata),
        .proc_stall_o (proc_stall),
        .bus_err_o    (bus_err),
        .gpio_i       (gpio_in),
        .gpio_o       (gpio_out),
        .gpio_oe_o    (gpio_oe),
        .timer_irq_o  (timer_irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // ==============================
    // processor port
    // ==============================
    // one access, returns at the falling edge where stall is low
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic is_write, input logic [2:0] op,
                              output logic [31:0] rdata, output logic err);
        int cycles;
        @(negedge clk);
        proc_req.addr  = addr;
        proc_req.wdata = wdata;
        proc_req.op    = op;
        proc_req.read  = ~is_write;
        proc_req.write = is_write;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (proc_stall && cycles < STALL_LIMIT);
        if (proc_stall)
        begin
            timeout_count++;
            $display("timeout: stall still high %0d cycles after access to 0x%08h",
                     cycles, addr);
        end
        else
            check_value("proc_stall_o cycles", 32'(cycles), 32'd3);
        rdata = proc_rdata;
        err   = bus_err;
        // idle again in the cycle stall falls
        proc_req.read  = 1'b0;
        proc_req.write = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [2:0] op);
        logic [31:0] rdata;
        logic        err;
        bus_access(addr, wdata, 1'b1, op, rdata, err);
        check_value($sformatf("bus_err_o @%08h", addr), 32'(err), 32'd0);
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [2:0] op,
                            output logic [31:0] rdata);
        logic err;
        bus_access(addr, 32'h0, 1'b0, op, rdata, err);
        check_value($sformatf("bus_err_o @%08h", addr), 32'(err), 32'd0);
    endtask

    function automatic int model_index(input logic [31:0] addr);
        return int'((addr >> 2) % soc_pkg::DMEM_WORDS);
    endfunction

    // kind bit 0 is a load, kind bit 1 expects a bus error
    task automatic run_vectors();
        logic [31:0] kind;
        logic [31:0] rdata;
        logic        err;
        int          base;
        int          done_records;
        done_records = 0;
        for (int r = 0; r < VEC_RECORDS; r++)
        begin
            base = r * 5;
            kind = vec_words[base];
            if (kind === 32'hf)
                break;
            bus_access(vec_words[base+2], vec_words[base+3], ~kind[0],
                       vec_words[base+1][2:0], rdata, err);
            check_value($sformatf("bus_err_o @%08h", vec_words[base+2]),
                        32'(err), 32'(kind[1]));
            if (kind[0] || kind[1])
                check_value($sformatf("proc_rdata_o @%08h", vec_words[base+2]),
                            rdata, vec_words[base+4]);
            done_records++;
        end
        if (done_records == 0)
        begin
            error_count++;
            $display("no vector records were read from the vector file");
        end
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial
    begin
        logic [31:0] rdata;
        logic [31:0] tmp;
        logic [31:0] gv;
        logic [31:0] ge;
        logic [31:0] cmp_lo;
        int          cycles;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        void'($urandom(42942));
        rst_n    = 1'b0;
        proc_req = '0;
        gpio_in  = '0;
        $readmemh("test/soc_vectors.mem", vec_words);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle outputs out of reset
        @(negedge clk);
        check_value("proc_stall_o", 32'(proc_stall), 32'd0);
        check_value("bus_err_o", 32'(bus_err), 32'd0);
        check_value("gpio_o", gpio_out, 32'h0);
        check_value("gpio_oe_o", gpio_oe, 32'h0);
        check_value("timer_irq_o", 32'(timer_irq), 32'd0);

        // fixed dmem, lane, sign and unmapped cases
        run_vectors();

        // random words, aliasing handled by the model
        for (int i = 0; i < RAND_ACCESSES; i++)
        begin
            tmp = $urandom();
            rnd_addr[i] = {soc_pkg::REGION_DMEM, tmp[27:2], 2'b00};
            rnd_data[i] = $urandom();
            bus_write(rnd_addr[i], rnd_data[i], soc_pkg::OP_LW);
            model_mem[model_index(rnd_addr[i])] = rnd_data[i];
        end
        for (int i = 0; i < RAND_ACCESSES; i++)
        begin
            bus_read(rnd_addr[i], soc_pkg::OP_LW, rdata);
            check_value($sformatf("proc_rdata_o @%08h", rnd_addr[i]), rdata,
                        model_mem[model_index(rnd_addr[i])]);
        end

        // ==============================
        // gpio
        // ==============================
        gv = $urandom();
        ge = $urandom();
        bus_write(GPIO_OUT_ADR, gv, soc_pkg::OP_LW);
        check_value("gpio_o", gpio_out, gv);
        bus_write(GPIO_OE_ADR, ge, soc_pkg::OP_LW);
        check_value("gpio_oe_o", gpio_oe, ge);
        // byte store hits lane 2 only
        bus_write({soc_pkg::REGION_GPIO, 28'h2}, 32'h0000_005a, soc_pkg::OP_LB);
        gv = {gv[31:24], 8'h5a, gv[15:0]};
        check_value("gpio_o", gpio_out, gv);
        bus_read(GPIO_OE_ADR, soc_pkg::OP_LW, rdata);
        check_value("proc_rdata_o gpio oe", rdata, ge);
        gpio_in = $urandom();
        repeat (3) @(negedge clk);
        bus_read(GPIO_IN_ADR, soc_pkg::OP_LW, rdata);
        check_value("proc_rdata_o gpio in", rdata, gpio_in);
        // input offset is read only
        bus_write(GPIO_IN_ADR, ~gpio_in, soc_pkg::OP_LW);
        bus_read(GPIO_IN_ADR, soc_pkg::OP_LW, rdata);
        check_value("proc_rdata_o gpio in", rdata, gpio_in);
        check_value("gpio_o", gpio_out, gv);

        // ==============================
        // timer
        // ==============================
        bus_read(MTIME_HI_ADR, soc_pkg::OP_LW, rdata);
        check_value("proc_rdata_o mtime hi", rdata, 32'h0);
        bus_read(MTIME_LO_ADR, soc_pkg::OP_LW, rdata);
        cmp_lo = rdata + 32'd40;
        bus_write(CMP_HI_ADR, 32'h0, soc_pkg::OP_LW);
        bus_write(CMP_LO_ADR, cmp_lo, soc_pkg::OP_LW);
        check_value("timer_irq_o", 32'(timer_irq), 32'd0);
        bus_read(CMP_LO_ADR, soc_pkg::OP_LW, rdata);
        check_value("proc_rdata_o mtimecmp lo", rdata, cmp_lo);
        cycles = 0;
        while (!timer_irq && cycles < IRQ_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!timer_irq)
        begin
            timeout_count++;
            $display("timeout: timer interrupt did not rise within %0d cycles", IRQ_LIMIT);
        end
        bus_write(CMP_HI_ADR, 32'hffff_ffff, soc_pkg::OP_LW);
        check_value("timer_irq_o", 32'(timer_irq), 32'd0);

        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- test/soc_assertions.sv
`timescale 1ns/1ps

module soc_assertions (
    input logic             clk,
    input logic             rst_n_i,
    input logic             proc_stall_o,
    input soc_pkg::wb_req_t wb_req_o,
    input soc_pkg::wb_rsp_t wb_rsp_i
);

    // ==============================
    // bridge bus protocol
    // ==============================
    // cyc and stb both up on the edge after the request
    cyc_start: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(proc_stall_o) |=> (wb_req_o.cyc && wb_req_o.stb))
        else $error("wishbone cycle did not start after the request");

    // request held until the slave terminates
    req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wb_req_o.cyc && !wb_rsp_i.ack && !wb_rsp_i.err) |=>
            ($stable(wb_req_o.adr) && $stable(wb_req_o.dat) &&
             $stable(wb_req_o.sel) && $stable(wb_req_o.we)))
        else $error("wishbone request changed before ack or err");

    // stall high for three sampled edges before falling
    stall_len: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(proc_stall_o) |->
            ($past(proc_stall_o, 2) && $past(proc_stall_o, 3) && !$past(proc_stall_o, 4)))
        else $error("processor stall not exactly three cycles");

endmodule

bind wb_master_bridge soc_assertions bridge_checks (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .proc_stall_o (proc_stall_o),
    .wb_req_o     (wb_req_o),
    .wb_rsp_i     (wb_rsp_i)
);

//--- hw/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic               clk,
    input  logic               rst_n_i,
    input  soc_pkg::proc_req_t proc_req_i,
    output logic [31:0]        proc_rdata_o,
    output logic               proc_stall_o,
    output logic               bus_err_o,
    input  logic [31:0]        gpio_i,
    output logic [31:0]        gpio_o,
    output logic [31:0]        gpio_oe_o,
    output logic               timer_irq_o
);

    // ==============================
    // bus wiring
    // ==============================
    // master side
    soc_pkg::wb_req_t bus_req;
    soc_pkg::wb_rsp_t bus_rsp;
    // slave side
    soc_pkg::wb_req_t dmem_req;
    soc_pkg::wb_rsp_t dmem_rsp;
    soc_pkg::wb_req_t clint_req;
    soc_pkg::wb_rsp_t clint_rsp;
    soc_pkg::wb_req_t gpio_req;
    soc_pkg::wb_rsp_t gpio_rsp;

    // processor port to bus cycles
    wb_master_bridge bridge_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .proc_req_i   (proc_req_i),
        .proc_rdata_o (proc_rdata_o),
        .proc_stall_o (proc_stall_o),
        .bus_err_o    (bus_err_o),
        .wb_req_o     (bus_req),
        .wb_rsp_i     (bus_rsp)
    );

    // region select and response return
    wb_addr_decoder decoder_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_req_i    (bus_req),
        .wb_rsp_o    (bus_rsp),
        .dmem_req_o  (dmem_req),
        .clint_req_o (clint_req),
        .gpio_req_o  (gpio_req),
        .dmem_rsp_i  (dmem_rsp),
        .clint_rsp_i (clint_rsp),
        .gpio_rsp_i  (gpio_rsp)
    );

    // ==============================
    // slaves
    // ==============================
    wb_data_ram #(
        .DEPTH (soc_pkg::DMEM_WORDS)
    ) dmem_inst (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_req_i (dmem_req),
        .wb_rsp_o (dmem_rsp)
    );

    gpio_regs gpio_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wb_req_i  (gpio_req),
        .wb_rsp_o  (gpio_rsp),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o)
    );

    clint_timer clint_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_req_i    (clint_req),
        .wb_rsp_o    (clint_rsp),
        .timer_irq_o (timer_irq_o)
    );

endmodule

//--- hw/clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
    input  logic             clk,
    input  logic             rst_n_i,
    input  soc_pkg::wb_req_t wb_req_i,
    output soc_pkg::wb_rsp_t wb_rsp_o,
    output logic             timer_irq_o
);

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic [31:0] rdat_q;
    logic        ack_q;
    logic        access;
    logic        wr;
    logic [3:0]  ofs;

    assign ofs    = wb_req_i.adr[3:0];
    assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign wr     = access & wb_req_i.we;

    // ==============================
    // mtime and mtimecmp
    // ==============================
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            mtime_q    <= '0;
            // all ones keeps the irq low out of reset
            mtimecmp_q <= '1;
            ack_q      <= 1'b0;
        end
        else
        begin
            ack_q <= access;
            // a write to either half replaces the increment
            if (wr && ofs == soc_pkg::CLINT_MTIME_LO_OFS)
                mtime_q[31:0] <= soc_pkg::byte_merge(mtime_q[31:0], wb_req_i.dat,
                                                     wb_req_i.sel);
            else if (wr && ofs == soc_pkg::CLINT_MTIME_HI_OFS)
                mtime_q[63:32] <= soc_pkg::byte_merge(mtime_q[63:32], wb_req_i.dat,
                                                      wb_req_i.sel);
            else
                mtime_q <= mtime_q + 64'd1;
            if (wr && ofs == soc_pkg::CLINT_CMP_LO_OFS)
                mtimecmp_q[31:0] <= soc_pkg::byte_merge(mtimecmp_q[31:0], wb_req_i.dat,
                                                        wb_req_i.sel);
            if (wr && ofs == soc_pkg::CLINT_CMP_HI_OFS)
                mtimecmp_q[63:32] <= soc_pkg::byte_merge(mtimecmp_q[63:32], wb_req_i.dat,
                                                         wb_req_i.sel);
        end
    end

    // word read, sampled with the strobe
    always_ff @(posedge clk)
    begin
        if (access)
        begin
            case (ofs)
                soc_pkg::CLINT_MTIME_LO_OFS: rdat_q <= mtime_q[31:0];
                soc_pkg::CLINT_MTIME_HI_OFS: rdat_q <= mtime_q[63:32];
                soc_pkg::CLINT_CMP_LO_OFS:   rdat_q <= mtimecmp_q[31:0];
                soc_pkg::CLINT_CMP_HI_OFS:   rdat_q <= mtimecmp_q[63:32];
                default:                     rdat_q <= '0;
            endcase
        end
    end

    // level interrupt, straight from the compare
    assign timer_irq_o = (mtime_q >= mtimecmp_q);
    assign wb_rsp_o    = '{dat: rdat_q, ack: ack_q, err: 1'b0};

endmodule

//--- hw/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs (
    input  logic             clk,
    input  logic             rst_n_i,
    input  soc_pkg::wb_req_t wb_req_i,
    output soc_pkg::wb_rsp_t wb_rsp_o,
    input  logic [31:0]      gpio_i,
    output logic [31:0]      gpio_o,
    output logic [31:0]      gpio_oe_o
);

    logic [31:0] out_q;
    logic [31:0] oe_q;
    // input synchronizer stages
    logic [31:0] sync1_q;
    logic [31:0] sync2_q;
    logic [31:0] rdat_q;
    logic        ack_q;
    logic        access;
    logic        wr;
    logic [3:0]  ofs;

    assign ofs    = wb_req_i.adr[3:0];
    assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign wr     = access & wb_req_i.we;

    // ==============================
    // control registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            out_q   <= '0;
            oe_q    <= '0;
            sync1_q <= '0;
            sync2_q <= '0;
            ack_q   <= 1'b0;
        end
        else
        begin
            ack_q   <= access;
            // two flops against metastability
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
            if (wr && ofs == soc_pkg::GPIO_OUT_OFS)
                out_q <= soc_pkg::byte_merge(out_q, wb_req_i.dat, wb_req_i.sel);
            if (wr && ofs == soc_pkg::GPIO_OE_OFS)
                oe_q <= soc_pkg::byte_merge(oe_q, wb_req_i.dat, wb_req_i.sel);
            // input offset read only
        end
    end

    // read mux, registered with ack
    always_ff @(posedge clk)
    begin
        if (access)
        begin
            case (ofs)
                soc_pkg::GPIO_OUT_OFS: rdat_q <= out_q;
                soc_pkg::GPIO_OE_OFS:  rdat_q <= oe_q;
                soc_pkg::GPIO_IN_OFS:  rdat_q <= sync2_q;
                default:               rdat_q <= '0;
            endcase
        end
    end

    assign gpio_o    = out_q;
    assign gpio_oe_o = oe_q;
    assign wb_rsp_o  = '{dat: rdat_q, ack: ack_q, err: 1'b0};

endmodule

//--- hw/wb_data_ram.sv
`timescale 1ns/1ps

module wb_data_ram #(
    parameter int DEPTH = soc_pkg::DMEM_WORDS
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  soc_pkg::wb_req_t wb_req_i,
    output soc_pkg::wb_rsp_t wb_rsp_o
);

    // word storage
    logic [31:0]              mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] idx;
    logic                     access;
    logic                     ack_q;
    logic [31:0]              rdat_q;

    // word index, upper address bits wrap
    assign idx    = wb_req_i.adr[$clog2(DEPTH)+1:2];
    // new strobe only, ack cycle excluded
    assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

    // ack one clock after stb, gone the next
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            ack_q <= 1'b0;
        else
            ack_q <= access;
    end

    // ==============================
    // array access
    // ==============================
    always_ff @(posedge clk)
    begin
        // byte-lane write
        if (access && wb_req_i.we)
            mem[idx] <= soc_pkg::byte_merge(mem[idx], wb_req_i.dat, wb_req_i.sel);
        // registered read, old word on a write
        if (access)
            rdat_q <= mem[idx];
    end

    // never signals an error
    assign wb_rsp_o = '{dat: rdat_q, ack: ack_q, err: 1'b0};

endmodule

//--- hw/wb_addr_decoder.sv
`timescale 1ns/1ps

module wb_addr_decoder (
    input  logic             clk,
    input  logic             rst_n_i,
    input  soc_pkg::wb_req_t wb_req_i,
    output soc_pkg::wb_rsp_t wb_rsp_o,
    output soc_pkg::wb_req_t dmem_req_o,
    output soc_pkg::wb_req_t clint_req_o,
    output soc_pkg::wb_req_t gpio_req_o,
    input  soc_pkg::wb_rsp_t dmem_rsp_i,
    input  soc_pkg::wb_rsp_t clint_rsp_i,
    input  soc_pkg::wb_rsp_t gpio_rsp_i
);

    logic [3:0]       region;
    logic             hit_dmem;
    logic             hit_clint;
    logic             hit_gpio;
    logic             hit_any;
    logic             unmapped_err_q;
    soc_pkg::wb_rsp_t sel_rsp;

    // region from the top nibble
    assign region    = wb_req_i.adr[31:28];
    assign hit_dmem  = (region == soc_pkg::REGION_DMEM);
    assign hit_clint = (region == soc_pkg::REGION_CLINT);
    assign hit_gpio  = (region == soc_pkg::REGION_GPIO);
    assign hit_any   = hit_dmem | hit_clint | hit_gpio;

    // ==============================
    // request fan-out
    // ==============================
    always_comb
    begin
        // every slave sees the request, only the hit gets stb
        dmem_req_o      = wb_req_i;
        clint_req_o     = wb_req_i;
        gpio_req_o      = wb_req_i;
        dmem_req_o.stb  = wb_req_i.stb & hit_dmem;
        clint_req_o.stb = wb_req_i.stb & hit_clint;
        gpio_req_o.stb  = wb_req_i.stb & hit_gpio;
    end

    // ==============================
    // response mux
    // ==============================
    always_comb
    begin
        // unmapped returns zero data
        sel_rsp = '0;
        if (hit_dmem)
            sel_rsp = dmem_rsp_i;
        else if (hit_clint)
            sel_rsp = clint_rsp_i;
        else if (hit_gpio)
            sel_rsp = gpio_rsp_i;
    end

    // unmapped strobe answered one clock later, like a slave ack
    // self-clearing so it lasts one cycle
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            unmapped_err_q <= 1'b0;
        else
            unmapped_err_q <= wb_req_i.cyc & wb_req_i.stb & ~hit_any & ~unmapped_err_q;
    end

    assign wb_rsp_o = '{
        dat: sel_rsp.dat,
        ack: sel_rsp.ack,
        err: sel_rsp.err | unmapped_err_q
    };

endmodule

//--- hw/wb_master_bridge.sv
`timescale 1ns/1ps

module wb_master_bridge (
    input  logic               clk,
    input  logic               rst_n_i,
    input  soc_pkg::proc_req_t proc_req_i,
    output logic [31:0]        proc_rdata_o,
    output logic               proc_stall_o,
    output logic               bus_err_o,
    output soc_pkg::wb_req_t   wb_req_o,
    input  soc_pkg::wb_rsp_t   wb_rsp_i
);

    // bus state
    logic        busy_q;
    logic        done_q;
    logic        err_q;
    logic [31:0] rdata_q;
    // request decode
    logic        req_valid;
    logic        bus_end;
    logic [1:0]  ofs;
    logic [3:0]  lane_sel;
    logic [31:0] lane_data;
    // load path
    logic [31:0] shifted;
    logic [31:0] load_data;

    assign req_valid = proc_req_i.read | proc_req_i.write;
    // cycle ends on either termination
    assign bus_end   = busy_q & (wb_rsp_i.ack | wb_rsp_i.err);
    assign ofs       = proc_req_i.addr[1:0];

    // ==============================
    // store lanes
    // ==============================
    always_comb
    begin
        case (proc_req_i.op)
            soc_pkg::OP_LB, soc_pkg::OP_LBU:
            begin
                // one lane, byte copied to all four
                lane_sel  = 4'b0001 << ofs;
                lane_data = {4{proc_req_i.wdata[7:0]}};
            end
            soc_pkg::OP_LH, soc_pkg::OP_LHU:
            begin
                // upper or lower half
                lane_sel  = 4'b0011 << {ofs[1], 1'b0};
                lane_data = {2{proc_req_i.wdata[15:0]}};
            end
            default:
            begin
                lane_sel  = 4'b1111;
                lane_data = proc_req_i.wdata;
            end
        endcase
    end

    // ==============================
    // load alignment
    // ==============================
    // addressed byte moved down to bit 0
    assign shifted = wb_rsp_i.dat >> {ofs, 3'b000};

    always_comb
    begin
        case (proc_req_i.op)
            soc_pkg::OP_LB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
            soc_pkg::OP_LH:  load_data = {{16{shifted[15]}}, shifted[15:0]};
            soc_pkg::OP_LBU: load_data = {24'b0, shifted[7:0]};
            soc_pkg::OP_LHU: load_data = {16'b0, shifted[15:0]};
            default:         load_data = wb_rsp_i.dat;
        endcase
    end

    // busy from the edge after the request until ack/err
    // done blocks a restart in the cycle stall falls
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end
        else
        begin
            done_q <= bus_end;
            err_q  <= bus_end & wb_rsp_i.err;
            if (bus_end)
                busy_q <= 1'b0;
            else if (req_valid && !done_q)
                busy_q <= 1'b1;
        end
    end

    // read data captured on the ending edge, zero on error
    always_ff @(posedge clk)
    begin
        if (bus_end)
            rdata_q <= wb_rsp_i.err ? 32'h0 : load_data;
    end

    // stall from the request itself, released by done
    assign proc_stall_o = req_valid & ~done_q;
    assign proc_rdata_o = rdata_q;
    assign bus_err_o    = err_q;

    // request fields straight from the held processor port
    assign wb_req_o = '{
        adr: {proc_req_i.addr[31:2], 2'b00},
        dat: lane_data,
        sel: lane_sel,
        we:  proc_req_i.write,
        cyc: busy_q,
        stb: busy_q
    };

endmodule

//--- hw/soc_pkg.sv
package soc_pkg;

    // ==============================
    // memory map
    // ==============================

    // region codes, matched against adr[31:28]
    localparam logic [3:0] REGION_DMEM  = 4'h0;
    localparam logic [3:0] REGION_CLINT = 4'h2;
    localparam logic [3:0] REGION_GPIO  = 4'h8;

    // data memory depth in 32-bit words
    localparam int DMEM_WORDS = 256;

    // gpio byte offsets
    localparam logic [3:0] GPIO_OUT_OFS = 4'h0;
    localparam logic [3:0] GPIO_OE_OFS  = 4'h4;
    localparam logic [3:0] GPIO_IN_OFS  = 4'h8;

    // clint byte offsets, 64-bit regs split in two words
    localparam logic [3:0] CLINT_MTIME_LO_OFS = 4'h0;
    localparam logic [3:0] CLINT_MTIME_HI_OFS = 4'h4;
    localparam logic [3:0] CLINT_CMP_LO_OFS   = 4'h8;
    localparam logic [3:0] CLINT_CMP_HI_OFS   = 4'hC;

    // ==============================
    // access sizes (funct3)
    // ==============================

    // stores reuse LB/LH/LW as SB/SH/SW
    localparam logic [2:0] OP_LB  = 3'b000;
    localparam logic [2:0] OP_LH  = 3'b001;
    localparam logic [2:0] OP_LW  = 3'b010;
    localparam logic [2:0] OP_LBU = 3'b100;
    localparam logic [2:0] OP_LHU = 3'b101;

    // ==============================
    // bus types
    // ==============================

    // processor memory port
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        read;
        logic        write;
        logic [2:0]  op;
    } proc_req_t;

    // master to slave
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
        logic        err;
    } wb_rsp_t;

    // merge new bytes into an old word under the byte selects
    function automatic logic [31:0] byte_merge(
        input logic [31:0] old_w,
        input logic [31:0] new_w,
        input logic [3:0]  sel
    );
        logic [31:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++)
        begin
            if (sel[i])
                res[8*i +: 8] = new_w[8*i +: 8];
        end
        return res;
    endfunction

endpackage
